// File: src/sdram_geom_pkg.sv
// geometry assumes one 16-bit SDR part with 4 banks, 4096 rows, 512 columns and 16-byte lines
package sdram_geom_pkg;

	// SDRAM array dimensions
	localparam int row_bits = 12;
	localparam int col_bits = 9;
	localparam int bank_bits = 2;

	// halfwords per burst, fixed by the mode register
	localparam int burst_len = 8;

	// cache line index taken from the low bits of the line address
	localparam int cache_idx_bits = 10;

	// row first, then burst column, bank last so neighbouring lines spread over banks
	typedef struct packed {
		logic [row_bits-1:0] row;
		logic [col_bits-4:0] col_hi;
		logic [bank_bits-1:0] bank;
	} line_adr_t;

	typedef enum logic {
		op_evict,
		op_refill
	} line_op_t;

	typedef struct packed {
		logic valid;
		line_op_t op;
		line_adr_t adr;
	} line_req_t;

endpackage

// File: src/sdram_cmd_pkg.sv
// command encodings target a CL2 SDR part with BL8 sequential bursts and a 12-bit address bus
package sdram_cmd_pkg;

	// commands as the sequencer decides them, encoded onto ras/cas/we later
	typedef enum logic [2:0] {
		nop,
		precharge,
		precharge_all,
		activate,
		write,
		read,
		auto_refresh,
		load_mode
	} sdram_op_t;

	// source of the SDRAM address bus
	typedef enum logic [1:0] {
		sel_mode,
		sel_row,
		sel_col,
		sel_a10
	} adr_sel_t;

	typedef enum logic [4:0] {
		st_reset, st_init_pchg, st_init_ref1, st_init_ref2, st_init_load_mode,
		st_idle,
		st_ref_pchg, st_refresh, st_ref_wait,
		st_wr_pchg, st_wr_act, st_write, st_wr_burst,
		st_rd_pchg, st_rd_act, st_read, st_rd_reg1, st_rd_reg2, st_rd_reg3,
		st_rd_first, st_rd_burst
	} seq_state_t;

	typedef struct packed {
		logic cke;
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [1:0] dqm;
		logic [1:0] ba;
		logic [11:0] adr;
	} sdram_pins_t;

	// burst writes, CL2, sequential, burst length 8
	localparam logic [11:0] mode_word = 12'h023;

endpackage

// File: src/sdram_timers.sv
// tRP, tRFC and tRCD counts suit a CL2 part near 100 MHz; check them for other clocks or parts
module sdram_timers #(
	parameter int init_cycles = 12500,
	parameter int refresh_cycles = 740
) (
	input logic sdram_clk,
	input logic reload_init,
	output logic init_done,
	input logic reload_trp,
	output logic trp_done,
	input logic reload_trfc,
	output logic trfc_done,
	input logic reload_trcd,
	output logic trcd_done,
	input logic reload_refresh,
	output logic need_refresh
);
	// command spacing in cycles
	localparam int t_rp = 4;
	localparam int t_rfc = 9;
	localparam int t_rcd = 2;

	localparam int n_tmr = 5;
	localparam int max_cnt = (init_cycles > refresh_cycles) ? init_cycles : refresh_cycles;
	localparam int cnt_w = $clog2(max_cnt + 1);
	localparam int tmr_load [n_tmr] = '{init_cycles, t_rp, t_rfc, t_rcd, refresh_cycles};

	logic [n_tmr-1:0] reload;
	logic [n_tmr-1:0] done;

	assign reload = {reload_refresh, reload_trcd, reload_trfc, reload_trp, reload_init};
	assign {need_refresh, trcd_done, trfc_done, trp_done, init_done} = done;

	for (genvar i = 0; i < n_tmr; i++) begin : g_tmr
		logic [cnt_w-1:0] cnt;

		assign done[i] = (cnt == '0);

		// reload wins, otherwise count down and hold at zero
		always_ff @(posedge sdram_clk) begin
			if (reload[i])
				cnt <= cnt_w'(tmr_load[i]);
			else if (!done[i])
				cnt <= cnt - 1'b1;
		end
	end

endmodule

// File: src/sdram_bank_tracker.sv
// open rows are only known after the first precharge all; requests must wait for init to finish
module sdram_bank_tracker (
	input logic sdram_clk,
	input sdram_geom_pkg::line_req_t line_req,
	input logic track_load,
	input logic track_open,
	input logic track_close_all,
	output logic row_switch
);
	import sdram_geom_pkg::*;

	localparam int n_banks = 2 ** bank_bits;

	logic [n_banks-1:0] active;
	logic [row_bits-1:0] open_row [n_banks];

	// bank and row of the request in flight
	logic [bank_bits-1:0] track_bank;
	logic [row_bits-1:0] track_row;

	always_ff @(posedge sdram_clk) begin
		if (track_load) begin
			track_bank <= line_req.adr.bank;
			track_row <= line_req.adr.row;
		end
	end

	// precharge all drops every bank, activate opens one
	always_ff @(posedge sdram_clk) begin
		if (track_close_all) begin
			active <= '0;
		end else if (track_open) begin
			active[track_bank] <= 1'b1;
			open_row[track_bank] <= track_row;
		end
	end

	// compare is the slow path, so the result is registered
	always_ff @(posedge sdram_clk) begin
		row_switch <= !active[line_req.adr.bank]
			|| (open_row[line_req.adr.bank] != line_req.adr.row);
	end

endmodule

// File: src/sdram_io_path.sv
// all SDRAM pins registered; cs_n tied low and cke held high, so no power-down modes
module sdram_io_path (
	input logic sdram_clk,
	input sdram_geom_pkg::line_req_t line_req,
	input sdram_cmd_pkg::sdram_op_t cmd,
	input sdram_cmd_pkg::adr_sel_t adr_sel,
	input logic dq_drive,
	input logic burst_run,
	input logic [3:0] beat,
	input logic load_cache_idx,
	output logic [11:0] cache_adr,
	output logic [31:0] cache_wdata,
	input logic [31:0] cache_rdata,
	output sdram_cmd_pkg::sdram_pins_t sdram_pins,
	inout wire [15:0] sdram_dq
);
	import sdram_geom_pkg::*;
	import sdram_cmd_pkg::*;

	sdram_pins_t pins_d;
	logic [cache_idx_bits-1:0] cache_idx;
	logic beat_q;
	logic [15:0] dq_out, dq_q, dq_in;
	logic dq_oe;

	always_comb begin
		pins_d.cke = 1'b1;
		pins_d.cs_n = 1'b0;
		// ras, cas, we
		case (cmd)
			precharge, precharge_all: {pins_d.ras_n, pins_d.cas_n, pins_d.we_n} = 3'b010;
			activate: {pins_d.ras_n, pins_d.cas_n, pins_d.we_n} = 3'b011;
			write: {pins_d.ras_n, pins_d.cas_n, pins_d.we_n} = 3'b100;
			read: {pins_d.ras_n, pins_d.cas_n, pins_d.we_n} = 3'b101;
			auto_refresh: {pins_d.ras_n, pins_d.cas_n, pins_d.we_n} = 3'b001;
			load_mode: {pins_d.ras_n, pins_d.cas_n, pins_d.we_n} = 3'b000;
			default: {pins_d.ras_n, pins_d.cas_n, pins_d.we_n} = 3'b111;
		endcase
		// masked outside bursts
		pins_d.dqm = burst_run ? 2'b00 : 2'b11;
		// mode register sits behind bank 0
		pins_d.ba = (cmd == load_mode) ? 2'b00 : line_req.adr.bank;
		case (adr_sel)
			sel_mode: pins_d.adr = mode_word;
			sel_col: pins_d.adr = 12'({line_req.adr.col_hi, 3'b000});
			sel_a10: pins_d.adr = 12'h400;
			default: pins_d.adr = line_req.adr.row;
		endcase
	end

	always_ff @(posedge sdram_clk) begin
		sdram_pins <= pins_d;
	end

	// beat_q tracks the sequencer's current beat, even beats carry the upper half
	assign dq_out = beat_q ? cache_rdata[15:0] : cache_rdata[31:16];

	always_ff @(posedge sdram_clk) begin
		beat_q <= beat[0];
		dq_oe <= dq_drive;
	end

	always_ff @(posedge sdram_clk) begin
		dq_q <= dq_out;
		// sampled every cycle, sequencer picks the valid beats
		dq_in <= sdram_dq;
	end

	assign sdram_dq = dq_oe ? dq_q : 16'hzzzz;

	// each halfword is offered to both cache halves, cache_we picks one
	assign cache_wdata = {dq_in, dq_in};

	always_ff @(posedge sdram_clk) begin
		if (load_cache_idx)
			cache_idx <= line_req.adr[cache_idx_bits-1:0];
	end

	assign cache_adr = {cache_idx, beat[2:1]};

endmodule

// File: src/sdram_sequencer.sv
// sequencing assumes CL2 and BL8; row hits skip precharge and activate, refresh closes all rows
module sdram_sequencer (
	input logic sdram_clk,
	input logic sdram_rst,
	input sdram_geom_pkg::line_req_t line_req,
	output logic line_ack,
	output logic reload_init,
	output logic reload_trp,
	output logic reload_trfc,
	output logic reload_trcd,
	output logic reload_refresh,
	input logic init_done,
	input logic trp_done,
	input logic trfc_done,
	input logic trcd_done,
	input logic need_refresh,
	output logic track_load,
	output logic track_open,
	output logic track_close_all,
	input logic row_switch,
	output sdram_cmd_pkg::sdram_op_t cmd,
	output sdram_cmd_pkg::adr_sel_t adr_sel,
	output logic dq_drive,
	output logic burst_run,
	output logic [3:0] beat,
	output logic [3:0] cache_we,
	output logic load_cache_idx
);
	import sdram_geom_pkg::*;
	import sdram_cmd_pkg::*;

	seq_state_t state, next_state;

	// burst counter runs 0..burst_len and parks at burst_len
	logic [3:0] burst_cnt, burst_nxt;
	logic burst_step;
	logic burst_last, burst_fin;

	assign burst_last = (burst_cnt == 4'(burst_len - 1));
	assign burst_fin = (burst_cnt == 4'(burst_len));

	always_comb begin
		if (!burst_step)
			burst_nxt = '0;
		else if (burst_fin)
			burst_nxt = burst_cnt;
		else
			burst_nxt = burst_cnt + 4'd1;
	end

	// io path forms the cache address one beat ahead
	assign beat = burst_nxt;

	always_ff @(posedge sdram_clk) begin
		if (sdram_rst) begin
			state <= st_reset;
			burst_cnt <= '0;
		end else begin
			state <= next_state;
			burst_cnt <= burst_nxt;
		end
	end

	always_comb begin
		next_state = state;
		cmd = nop;
		adr_sel = sel_row;
		dq_drive = 1'b0;
		burst_run = 1'b0;
		burst_step = 1'b0;
		cache_we = 4'b0000;
		load_cache_idx = 1'b0;
		line_ack = 1'b0;
		reload_init = 1'b0;
		reload_trp = 1'b0;
		reload_trfc = 1'b0;
		reload_trcd = 1'b0;
		reload_refresh = 1'b0;
		track_load = 1'b0;
		track_open = 1'b0;
		track_close_all = 1'b0;
		case (state)
			st_reset: begin
				// load every timer so none starts out unknown
				reload_init = 1'b1;
				reload_trp = 1'b1;
				reload_trfc = 1'b1;
				reload_trcd = 1'b1;
				reload_refresh = 1'b1;
				next_state = st_init_pchg;
			end
			st_init_pchg: begin
				if (init_done) begin
					cmd = precharge_all;
					adr_sel = sel_a10;
					track_close_all = 1'b1;
					reload_trp = 1'b1;
					next_state = st_init_ref1;
				end
			end
			st_init_ref1: begin
				if (trp_done) begin
					cmd = auto_refresh;
					reload_trfc = 1'b1;
					next_state = st_init_ref2;
				end
			end
			st_init_ref2: begin
				if (trfc_done) begin
					cmd = auto_refresh;
					reload_trfc = 1'b1;
					next_state = st_init_load_mode;
				end
			end
			st_init_load_mode: begin
				if (trfc_done) begin
					cmd = load_mode;
					adr_sel = sel_mode;
					reload_refresh = 1'b1;
					next_state = st_idle;
				end
			end
			st_idle: begin
				// refresh wins over a waiting request
				if (need_refresh) begin
					next_state = st_ref_pchg;
				end else if (line_req.valid) begin
					load_cache_idx = 1'b1;
					next_state = (line_req.op == op_evict) ? st_wr_pchg : st_rd_pchg;
				end
			end
			st_ref_pchg: begin
				cmd = precharge_all;
				adr_sel = sel_a10;
				track_close_all = 1'b1;
				reload_trp = 1'b1;
				next_state = st_refresh;
			end
			st_refresh: begin
				if (trp_done) begin
					cmd = auto_refresh;
					reload_trfc = 1'b1;
					next_state = st_ref_wait;
				end
			end
			st_ref_wait: begin
				if (trfc_done) begin
					reload_refresh = 1'b1;
					next_state = st_idle;
				end
			end
			st_wr_pchg, st_rd_pchg: begin
				// row_switch is valid here, one cycle after idle saw the request
				track_load = 1'b1;
				if (row_switch) begin
					cmd = precharge;
					reload_trp = 1'b1;
					next_state = (state == st_wr_pchg) ? st_wr_act : st_rd_act;
				end else begin
					next_state = (state == st_wr_pchg) ? st_write : st_read;
				end
			end
			st_wr_act, st_rd_act: begin
				if (trp_done) begin
					cmd = activate;
					adr_sel = sel_row;
					track_open = 1'b1;
					reload_trcd = 1'b1;
					next_state = (state == st_wr_act) ? st_write : st_read;
				end
			end
			st_write: begin
				if (trcd_done) begin
					// first halfword goes out with the command
					cmd = write;
					adr_sel = sel_col;
					dq_drive = 1'b1;
					burst_run = 1'b1;
					burst_step = 1'b1;
					next_state = st_wr_burst;
				end
			end
			st_wr_burst: begin
				burst_step = 1'b1;
				if (burst_fin) begin
					line_ack = 1'b1;
					next_state = st_idle;
				end else begin
					dq_drive = 1'b1;
					burst_run = 1'b1;
				end
			end
			st_read: begin
				if (trcd_done) begin
					cmd = read;
					adr_sel = sel_col;
					burst_run = 1'b1;
					next_state = st_rd_reg1;
				end
			end
			// command register, CAS latency, then input register
			st_rd_reg1: begin
				burst_run = 1'b1;
				next_state = st_rd_reg2;
			end
			st_rd_reg2: begin
				burst_run = 1'b1;
				next_state = st_rd_reg3;
			end
			st_rd_reg3: begin
				burst_run = 1'b1;
				next_state = st_rd_first;
			end
			st_rd_first: begin
				// beat 0 into the upper half of word 0
				burst_run = 1'b1;
				cache_we = 4'b1100;
				next_state = st_rd_burst;
			end
			st_rd_burst: begin
				burst_step = 1'b1;
				if (burst_last) begin
					line_ack = 1'b1;
					next_state = st_idle;
				end else begin
					burst_run = 1'b1;
					cache_we = {{2{burst_cnt[0]}}, {2{~burst_cnt[0]}}};
				end
			end
			default: next_state = st_reset;
		endcase
	end

endmodule

// File: src/sdram_ctrl_top.sv
// one line per request, requester must hold valid until line_ack; timer parameters in cycles
module sdram_ctrl_top #(
	parameter int init_cycles = 12500,
	parameter int refresh_cycles = 740
) (
	input logic sdram_clk,
	input logic sdram_rst,
	input sdram_geom_pkg::line_req_t line_req,
	output logic line_ack,
	output logic [11:0] cache_adr,
	output logic [3:0] cache_we,
	output logic [31:0] cache_wdata,
	input logic [31:0] cache_rdata,
	output sdram_cmd_pkg::sdram_pins_t sdram_pins,
	inout wire [15:0] sdram_dq
);
	import sdram_cmd_pkg::*;

	// sequencer to timers
	logic reload_init, reload_trp, reload_trfc, reload_trcd, reload_refresh;
	logic init_done, trp_done, trfc_done, trcd_done, need_refresh;

	// sequencer to bank tracker
	logic track_load, track_open, track_close_all, row_switch;

	// sequencer to io path
	sdram_op_t cmd;
	adr_sel_t adr_sel;
	logic dq_drive, burst_run, load_cache_idx;
	logic [3:0] beat;

	sdram_sequencer sdram_sequencer_i (.*);

	sdram_timers #(
		.init_cycles(init_cycles),
		.refresh_cycles(refresh_cycles)
	) sdram_timers_i (.*);

	sdram_bank_tracker sdram_bank_tracker_i (.*);

	sdram_io_path sdram_io_path_i (.*);

endmodule

// File: tb/sdram_model.sv
// behavioural SDRAM with CL2 and BL8 only; no timing checks, dqm seen on writes only, no refresh loss
module sdram_model (
	input logic sdram_clk,
	input logic sdram_rst,
	input sdram_cmd_pkg::sdram_pins_t pins,
	inout wire [15:0] dq
);
	timeunit 1ns;
	timeprecision 100ps;
	import sdram_cmd_pkg::*;

	logic [15:0] mem [logic [22:0]];
	logic [3:0] bank_open;
	logic [11:0] open_row [4];
	int act_cnt, ref_cnt, pchg_cnt, rule_errors;
	int init_pall, init_refs;
	logic init_bad, mode_loaded;
	logic [11:0] mode_seen;
	// burst bookkeeping
	int wr_left, rd_left;
	logic [1:0] wr_ba, rd_ba;
	logic [11:0] wr_row, rd_row;
	logic [8:0] wr_col, rd_col;
	logic [15:0] drv_data;
	logic drv_en;

	assign dq = drv_en ? drv_data : 16'hzzzz;

	initial begin
		act_cnt = 0;
		ref_cnt = 0;
		pchg_cnt = 0;
		rule_errors = 0;
		init_pall = 0;
		init_refs = 0;
		init_bad = 1'b0;
		mode_loaded = 1'b0;
		mode_seen = '0;
		bank_open = '0;
		wr_left = 0;
		rd_left = 0;
		drv_en = 1'b0;
		drv_data = '0;
	end

	function automatic logic [15:0] peek(input logic [1:0] ba, input logic [11:0] row,
		input logic [8:0] col);
		logic [22:0] key;
		key = {ba, row, col};
		if (mem.exists(key))
			return mem[key];
		return 16'hxxxx;
	endfunction

	// reads and writes need a finished init and an open bank
	task automatic check_access(input logic [1:0] ba);
		if (!mode_loaded)
			init_bad = 1'b1;
		if (!bank_open[ba]) begin
			rule_errors++;
			$display("sdram model: read or write to closed bank %0d", ba);
		end
	endtask

	always @(posedge sdram_clk) begin
		logic [2:0] rcw;
		logic [1:0] ba;
		logic [11:0] a;
		rcw = {pins.ras_n, pins.cas_n, pins.we_n};
		ba = pins.ba;
		a = pins.adr;
		if (!sdram_rst) begin
			// no power-down, clock enable stays high
			if (!pins.cke) begin
				rule_errors++;
				$display("sdram model: cke low outside reset");
			end
			// read data out, first beat one edge after the command edge
			if (rd_left > 0) begin
				drv_en <= 1'b1;
				drv_data <= peek(rd_ba, rd_row, rd_col + 9'(8 - rd_left));
				rd_left--;
			end else begin
				drv_en <= 1'b0;
			end
			if (!pins.cs_n) begin
				case (rcw)
					3'b011: begin
						if (!mode_loaded)
							init_bad = 1'b1;
						if (bank_open[ba]) begin
							rule_errors++;
							$display("sdram model: activate to already open bank %0d", ba);
						end
						bank_open[ba] = 1'b1;
						open_row[ba] = a;
						act_cnt++;
					end
					3'b010: begin
						if (a[10]) begin
							bank_open = '0;
							if (!mode_loaded)
								init_pall++;
						end else begin
							if (!mode_loaded)
								init_bad = 1'b1;
							bank_open[ba] = 1'b0;
							pchg_cnt++;
						end
					end
					3'b001: begin
						if (bank_open != '0) begin
							rule_errors++;
							$display("sdram model: auto refresh with a bank still open");
						end
						if (!mode_loaded) begin
							if (init_pall == 0)
								init_bad = 1'b1;
							init_refs++;
						end
						ref_cnt++;
					end
					3'b000: begin
						if (init_pall == 0 || init_refs < 2)
							init_bad = 1'b1;
						mode_loaded = 1'b1;
						mode_seen = a;
					end
					3'b100: begin
						check_access(ba);
						wr_ba = ba;
						wr_row = open_row[ba];
						wr_col = a[8:0];
						wr_left = 8;
					end
					3'b101: begin
						check_access(ba);
						rd_ba = ba;
						rd_row = open_row[ba];
						rd_col = a[8:0];
						rd_left = 8;
					end
					default: ;
				endcase
			end
			// write data is on the bus from the command edge on
			if (wr_left > 0) begin
				// a masked beat is not stored
				if (pins.dqm != 2'b00) begin
					rule_errors++;
					$display("sdram model: write beat masked by dqm %b", pins.dqm);
				end else begin
					mem[{wr_ba, wr_row, wr_col + 9'(8 - wr_left)}] = dq;
				end
				wr_left--;
			end
		end
	end

endmodule

// File: tb/tb_sdram_ctrl.sv
// directed tests with short init and refresh intervals; needs the SDRAM model beside the DUT
module tb_sdram_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import sdram_geom_pkg::*;
	import sdram_cmd_pkg::*;

	localparam int init_cycles = 20;
	localparam int refresh_cycles = 300;

	logic sdram_clk;
	logic sdram_rst;
	line_req_t line_req;
	logic line_ack;
	logic [11:0] cache_adr;
	logic [3:0] cache_we;
	logic [31:0] cache_wdata;
	logic [31:0] cache_rdata = '0;
	sdram_pins_t sdram_pins;
	wire [15:0] sdram_dq;

	// cache RAM with a registered read and a host write port for the tests
	logic [31:0] cache_mem [4096];
	logic host_we;
	logic [11:0] host_adr;
	logic [31:0] host_data;

	int errors;
	logic [31:0] ref_line [4];
	line_adr_t adr_a, adr_a2, adr_b;

	sdram_ctrl_top #(
		.init_cycles(init_cycles),
		.refresh_cycles(refresh_cycles)
	) sdram_ctrl_top_i (.*);

	sdram_model model_i (
		.sdram_clk(sdram_clk),
		.sdram_rst(sdram_rst),
		.pins(sdram_pins),
		.dq(sdram_dq)
	);

	initial begin
		sdram_clk = 1'b0;
		forever #2 sdram_clk = ~sdram_clk;
	end

	always @(posedge sdram_clk) begin
		cache_rdata <= cache_mem[cache_adr];
		for (int b = 0; b < 4; b++) begin
			if (cache_we[b])
				cache_mem[cache_adr][8*b +: 8] <= cache_wdata[8*b +: 8];
		end
		if (host_we)
			cache_mem[host_adr] <= host_data;
	end

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic write_cache_word(input logic [9:0] idx, input int w, input logic [31:0] data);
		@(posedge sdram_clk);
		host_we <= 1'b1;
		host_adr <= {idx, 2'(w)};
		host_data <= data;
		@(posedge sdram_clk);
		host_we <= 1'b0;
	endtask

	// one request, held until line_ack is seen
	task automatic run_line(input line_op_t op, input line_adr_t adr);
		int t;
		logic seen;
		seen = 1'b0;
		t = 0;
		@(posedge sdram_clk);
		line_req <= '{valid: 1'b1, op: op, adr: adr};
		while (!seen && t < 1000) begin
			@(negedge sdram_clk);
			if (line_ack)
				seen = 1'b1;
			t++;
		end
		@(posedge sdram_clk);
		line_req <= '0;
		// last write beat reaches the SDRAM on the edge after line_ack
		@(negedge sdram_clk);
		if (!seen) begin
			errors++;
			$display("no line acknowledge within 1000 cycles for line %h", adr);
		end
	endtask

	// start a test right after a refresh so no other refresh gets in the way
	task automatic wait_refresh();
		int r0;
		int t;
		r0 = model_i.ref_cnt;
		t = 0;
		while (model_i.ref_cnt == r0 && t < refresh_cycles + 100) begin
			@(negedge sdram_clk);
			t++;
		end
		if (model_i.ref_cnt == r0) begin
			errors++;
			$display("no auto refresh seen within %0d cycles", refresh_cycles + 100);
		end
	endtask

	task automatic init_order();
		int t;
		t = 0;
		while (!model_i.mode_loaded && t < init_cycles + 200) begin
			@(negedge sdram_clk);
			t++;
		end
		if (!model_i.mode_loaded) begin
			errors++;
			$display("mode register never loaded after reset");
		end
		if (model_i.init_bad) begin
			errors++;
			$display("init commands came out of order or a read/write came before load mode");
		end
		check_hex("init_pall", model_i.init_pall, 1);
		check_hex("init_refs", model_i.init_refs, 2);
		check_hex("mode_seen", model_i.mode_seen, 32'h023);
	endtask

	task automatic line_round_trip();
		logic [9:0] idx;
		logic [15:0] exp;
		idx = adr_a[9:0];
		for (int w = 0; w < 4; w++) begin
			ref_line[w] = $urandom;
			write_cache_word(idx, w, ref_line[w]);
		end
		run_line(op_evict, adr_a);
		// upper half of each word goes first
		for (int i = 0; i < 8; i++) begin
			exp = i[0] ? ref_line[i/2][15:0] : ref_line[i/2][31:16];
			check_hex("sdram_halfword", model_i.peek(adr_a.bank, adr_a.row,
				{adr_a.col_hi, 3'b000} + 9'(i)), exp);
		end
		for (int w = 0; w < 4; w++)
			write_cache_word(idx, w, ~ref_line[w]);
		run_line(op_refill, adr_a);
		for (int w = 0; w < 4; w++)
			check_hex("cache_mem", cache_mem[{idx, 2'(w)}], ref_line[w]);
	endtask

	task automatic row_hit_reuse();
		int act0;
		int pchg0;
		wait_refresh();
		run_line(op_refill, adr_a);
		act0 = model_i.act_cnt;
		run_line(op_refill, adr_a);
		check_hex("act_cnt", model_i.act_cnt, act0);
		pchg0 = model_i.pchg_cnt;
		// same bank, other row
		run_line(op_evict, adr_a2);
		check_hex("act_cnt", model_i.act_cnt, act0 + 1);
		check_hex("pchg_cnt", model_i.pchg_cnt, pchg0 + 1);
	endtask

	task automatic bank_independence();
		int act0;
		wait_refresh();
		run_line(op_refill, adr_a);
		run_line(op_evict, adr_b);
		act0 = model_i.act_cnt;
		for (int k = 0; k < 2; k++) begin
			run_line(op_refill, adr_a);
			run_line(op_evict, adr_b);
		end
		check_hex("act_cnt", model_i.act_cnt, act0);
	endtask

	task automatic refresh_closes_rows();
		int r0;
		int act0;
		logic [9:0] idx;
		r0 = model_i.ref_cnt;
		repeat (1600) @(negedge sdram_clk);
		// at least one refresh per interval
		if (model_i.ref_cnt - r0 < 1600 / refresh_cycles) begin
			errors++;
			$display("only %0d auto refreshes in 1600 idle cycles", model_i.ref_cnt - r0);
		end
		idx = adr_a[9:0];
		for (int w = 0; w < 4; w++)
			write_cache_word(idx, w, 32'h0);
		act0 = model_i.act_cnt;
		run_line(op_refill, adr_a);
		check_hex("act_cnt", model_i.act_cnt, act0 + 1);
		for (int w = 0; w < 4; w++)
			check_hex("cache_mem", cache_mem[{idx, 2'(w)}], ref_line[w]);
	endtask

	initial begin
		void'($urandom(32'h8ab9));
		errors = 0;
		sdram_rst = 1'b1;
		line_req = '0;
		host_we = 1'b0;
		host_adr = '0;
		host_data = '0;
		adr_a.row = 12'($urandom);
		adr_a.col_hi = 6'($urandom);
		adr_a.bank = 2'd1;
		adr_a2 = adr_a;
		adr_a2.row = adr_a.row ^ 12'h010;
		adr_b = adr_a;
		adr_b.row = adr_a.row ^ 12'h800;
		adr_b.bank = 2'd2;
		repeat (16) @(posedge sdram_clk);
		sdram_rst <= 1'b0;
		init_order();
		line_round_trip();
		row_hit_reuse();
		bank_independence();
		refresh_closes_rows();
		$display("errors: testbench %0d, sdram model %0d", errors, model_i.rule_errors);
		if (errors == 0 && model_i.rule_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: sdram_ctrl.f
src/sdram_geom_pkg.sv
src/sdram_cmd_pkg.sv
src/sdram_timers.sv
src/sdram_bank_tracker.sv
src/sdram_io_path.sv
src/sdram_sequencer.sv
src/sdram_ctrl_top.sv
tb/sdram_model.sv
tb/tb_sdram_ctrl.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sdram_ctrl.f --top-module tb_sdram_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test completed successfully$" sim.log; then
	echo "simulation passed"
else
	echo "simulation did not pass"
	exit 1
fi
